// ==== design/cache_data_array.sv ====
`timescale 1ns/1ps

module cache_data_array
    import cache_pkg::*;
(
    input  logic               clk,
    input  t_cache_addr        i_addr,
    input  logic [WAY_W-1:0]   i_hit_way,
    input  logic [WAY_W-1:0]   i_victim_way,
    input  logic               i_we,
    input  logic               i_lru_update,
    input  logic [WORD_W-1:0]  i_wdata,
    input  logic               i_block_we,
    input  logic [BLOCK_W-1:0] i_fill_block,
    output logic [WORD_W-1:0]  o_rdata,
    output logic [BLOCK_W-1:0] o_victim_block
);

    logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] blocks [WAYS][SETS];

    logic [INDEX_W-1:0]    index;
    logic [WORD_SEL_W-1:0] word;

    assign index = i_addr.fields.index;
    assign word  = i_addr.fields.word;

    // Read port for hits, block port for write-back.
    assign o_rdata        = blocks[i_hit_way][index][word];
    assign o_victim_block = blocks[i_victim_way][index];

    // --------------------------------------------------
    // Write.
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_block_we) begin
            blocks[i_victim_way][index] <= i_fill_block;
        end else if (i_lru_update && i_we) begin
            blocks[i_hit_way][index][word] <= i_wdata;
        end
    end

endmodule

// ==== design/cache_lru.sv ====
`timescale 1ns/1ps

module cache_lru
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               arstn,
    input  logic [INDEX_W-1:0] i_index,
    input  logic               i_lru_update,
    input  logic [WAY_W-1:0]   i_hit_way,
    input  logic [WAYS-1:0]    i_valid_bits,
    output logic [WAY_W-1:0]   o_victim_way
);

    // Age 0 is most recently used.
    logic [WAY_W-1:0] age [SETS][WAYS];
    logic [WAY_W-1:0] hit_age;

    assign hit_age = age[i_index][i_hit_way];

    // --------------------------------------------------
    // Age update.
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    age[s][w] <= WAY_W'(w);
                end
            end
        end else if (i_lru_update) begin
            for (int w = 0; w < WAYS; w++) begin
                if (WAY_W'(w) == i_hit_way) begin
                    age[i_index][w] <= '0;
                end else if (age[i_index][w] < hit_age) begin
                    age[i_index][w] <= age[i_index][w] + 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // Victim choice.
    // --------------------------------------------------
    always_comb begin
        o_victim_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (age[i_index][w] == WAY_W'(WAYS - 1)) begin
                o_victim_way = WAY_W'(w);
            end
        end
        // Lowest invalid way wins over the oldest.
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!i_valid_bits[w]) begin
                o_victim_way = WAY_W'(w);
            end
        end
    end

endmodule

// ==== design/cache_pkg.sv ====
package cache_pkg;

    // --------------------------------------------------
    // Cache geometry.
    // --------------------------------------------------
    localparam int WAYS            = 4;
    localparam int SETS            = 16;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int WORD_W          = 32;
    localparam int ADDR_W          = 32;
    localparam int BLOCK_W         = WORDS_PER_BLOCK * WORD_W;

    // Field widths.
    localparam int WAY_W      = $clog2(WAYS);
    localparam int INDEX_W    = $clog2(SETS);
    localparam int WORD_SEL_W = $clog2(WORDS_PER_BLOCK);
    localparam int OFFSET_W   = WORD_SEL_W + 2;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

    // --------------------------------------------------
    // Cache address.
    // --------------------------------------------------
    // Flat byte address for the memory side, split fields for lookup.
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            logic [TAG_W-1:0]                 tag;
            logic [INDEX_W-1:0]               index;
            logic [WORD_SEL_W-1:0]            word;
            logic [OFFSET_W-WORD_SEL_W-1:0]   byte_sel;
        } fields;
    } t_cache_addr;

endpackage

// ==== design/cache_tag_array.sv ====
`timescale 1ns/1ps

module cache_tag_array
    import cache_pkg::*;
(
    input  logic             clk,
    input  logic             arstn,
    input  t_cache_addr      i_addr,
    input  logic [WAY_W-1:0] i_victim_way,
    input  logic             i_valid_update,
    input  logic             i_lru_update,
    input  logic             i_we,
    output logic             o_hit,
    output logic [WAY_W-1:0] o_hit_way,
    output logic             o_dirty,
    output logic [TAG_W-1:0] o_victim_tag,
    output logic [WAYS-1:0]  o_valid_bits
);

    logic [TAG_W-1:0]   tags  [WAYS][SETS];
    logic [SETS-1:0]    valid [WAYS];
    logic [SETS-1:0]    dirty [WAYS];
    logic [WAYS-1:0]    match;
    logic [INDEX_W-1:0] index;

    assign index = i_addr.fields.index;

    // --------------------------------------------------
    // Lookup.
    // --------------------------------------------------
    always_comb begin
        o_hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            o_valid_bits[w] = valid[w][index];
            match[w]        = valid[w][index] && (tags[w][index] == i_addr.fields.tag);
            if (match[w]) begin
                o_hit_way = WAY_W'(w);
            end
        end
        o_hit = |match;
    end

    // Only read by the FSM on a miss.
    assign o_dirty      = dirty[i_victim_way][index];
    assign o_victim_tag = tags[i_victim_way][index];

    // --------------------------------------------------
    // Update.
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_valid_update) begin
            tags[i_victim_way][index] <= i_addr.fields.tag;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int w = 0; w < WAYS; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
        end else if (i_valid_update) begin
            // Freshly filled block is clean.
            valid[i_victim_way][index] <= 1'b1;
            dirty[i_victim_way][index] <= 1'b0;
        end else if (i_lru_update && i_we) begin
            dirty[o_hit_way][index] <= 1'b1;
        end
    end

endmodule

// ==== design/data_cache.sv ====
`timescale 1ns/1ps

module data_cache
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              arstn,

    // Processor port.
    input  logic              i_req,
    input  logic              i_we,
    input  t_cache_addr       i_addr,
    input  logic [WORD_W-1:0] i_wdata,
    output logic [WORD_W-1:0] o_rdata,
    output logic              o_stall,

    // Memory port.
    output logic              o_mem_ar_valid,
    output t_cache_addr       o_mem_ar_addr,
    input  logic              i_mem_ar_ready,
    input  logic              i_mem_r_valid,
    input  logic [WORD_W-1:0] i_mem_r_data,
    input  logic              i_mem_r_last,
    output logic              o_mem_aw_valid,
    output t_cache_addr       o_mem_aw_addr,
    input  logic              i_mem_aw_ready,
    output logic              o_mem_w_valid,
    output logic [WORD_W-1:0] o_mem_w_data,
    output logic              o_mem_w_last,
    input  logic              i_mem_w_ready,
    input  logic              i_mem_b_valid
);

    // FSM controls.
    logic data_block_write_en;
    logic valid_update;
    logic lru_update;
    logic start_write;
    logic start_read;
    logic addr_control;

    // Datapath status.
    logic               hit;
    logic [WAY_W-1:0]   hit_way;
    logic               dirty;
    logic [TAG_W-1:0]   victim_tag;
    logic [WAYS-1:0]    valid_bits;
    logic [WAY_W-1:0]   victim_way;
    logic               r_last;
    logic               b_resp;
    logic [BLOCK_W-1:0] fill_block;
    logic [BLOCK_W-1:0] victim_block;

    // --------------------------------------------------
    // Control.
    // --------------------------------------------------
    data_cache_fsm u_fsm (
        .clk                   (clk),
        .arstn                 (arstn),
        .i_start_check         (i_req),
        .i_hit                 (hit),
        .i_dirty               (dirty),
        .i_r_last              (r_last),
        .i_b_resp              (b_resp),
        .o_stall               (o_stall),
        .o_data_block_write_en (data_block_write_en),
        .o_valid_update        (valid_update),
        .o_lru_update          (lru_update),
        .o_start_write         (start_write),
        .o_start_read          (start_read),
        .o_addr_control        (addr_control)
    );

    // --------------------------------------------------
    // Storage.
    // --------------------------------------------------
    cache_tag_array u_tags (
        .clk            (clk),
        .arstn          (arstn),
        .i_addr         (i_addr),
        .i_victim_way   (victim_way),
        .i_valid_update (valid_update),
        .i_lru_update   (lru_update),
        .i_we           (i_we),
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_dirty        (dirty),
        .o_victim_tag   (victim_tag),
        .o_valid_bits   (valid_bits)
    );

    cache_lru u_lru (
        .clk          (clk),
        .arstn        (arstn),
        .i_index      (i_addr.fields.index),
        .i_lru_update (lru_update),
        .i_hit_way    (hit_way),
        .i_valid_bits (valid_bits),
        .o_victim_way (victim_way)
    );

    cache_data_array u_data (
        .clk            (clk),
        .i_addr         (i_addr),
        .i_hit_way      (hit_way),
        .i_victim_way   (victim_way),
        .i_we           (i_we),
        .i_lru_update   (lru_update),
        .i_wdata        (i_wdata),
        .i_block_we     (data_block_write_en),
        .i_fill_block   (fill_block),
        .o_rdata        (o_rdata),
        .o_victim_block (victim_block)
    );

    // --------------------------------------------------
    // Memory side.
    // --------------------------------------------------
    mem_burst_ctrl u_mem (
        .clk            (clk),
        .arstn          (arstn),
        .i_start_read   (start_read),
        .i_start_write  (start_write),
        .i_addr_control (addr_control),
        .i_addr         (i_addr),
        .i_victim_tag   (victim_tag),
        .i_victim_block (victim_block),
        .o_r_last       (r_last),
        .o_b_resp       (b_resp),
        .o_fill_block   (fill_block),
        .o_mem_ar_valid (o_mem_ar_valid),
        .o_mem_ar_addr  (o_mem_ar_addr),
        .i_mem_ar_ready (i_mem_ar_ready),
        .i_mem_r_valid  (i_mem_r_valid),
        .i_mem_r_data   (i_mem_r_data),
        .i_mem_r_last   (i_mem_r_last),
        .o_mem_aw_valid (o_mem_aw_valid),
        .o_mem_aw_addr  (o_mem_aw_addr),
        .i_mem_aw_ready (i_mem_aw_ready),
        .o_mem_w_valid  (o_mem_w_valid),
        .o_mem_w_data   (o_mem_w_data),
        .o_mem_w_last   (o_mem_w_last),
        .i_mem_w_ready  (i_mem_w_ready),
        .i_mem_b_valid  (i_mem_b_valid)
    );

endmodule

// ==== design/data_cache_fsm.sv ====
`timescale 1ns/1ps

module data_cache_fsm
    import cache_pkg::*;
(
    input  logic clk,
    input  logic arstn,

    // Status from the datapath.
    input  logic i_start_check,
    input  logic i_hit,
    input  logic i_dirty,
    input  logic i_r_last,
    input  logic i_b_resp,

    // Control to the datapath.
    output logic o_stall,
    output logic o_data_block_write_en,
    output logic o_valid_update,
    output logic o_lru_update,
    output logic o_start_write,
    output logic o_start_read,
    output logic o_addr_control
);

    typedef enum logic [1:0] {
        IDLE        = 2'b00,
        COMPARE_TAG = 2'b01,
        ALLOCATE    = 2'b10,
        WRITE_BACK  = 2'b11
    } t_state;

    t_state state;
    t_state next_state;

    // --------------------------------------------------
    // State register.
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // --------------------------------------------------
    // Next state.
    // --------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (i_start_check) begin
                    next_state = COMPARE_TAG;
                end
            end
            COMPARE_TAG: begin
                if (i_hit) begin
                    next_state = IDLE;
                end else if (i_dirty) begin
                    next_state = WRITE_BACK;
                end else begin
                    next_state = ALLOCATE;
                end
            end
            // Fill is done once the last beat is buffered.
            ALLOCATE: begin
                if (i_r_last) begin
                    next_state = COMPARE_TAG;
                end
            end
            WRITE_BACK: begin
                if (i_b_resp) begin
                    next_state = ALLOCATE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // --------------------------------------------------
    // Outputs.
    // --------------------------------------------------
    always_comb begin
        o_stall               = 1'b1;
        o_data_block_write_en = 1'b0;
        o_valid_update        = 1'b0;
        o_lru_update          = 1'b0;
        o_start_write         = 1'b0;
        o_start_read          = 1'b0;
        o_addr_control        = 1'b1;
        case (state)
            COMPARE_TAG: begin
                o_stall      = ~i_hit;
                o_lru_update = i_hit;
                // Victim address and block are latched here.
                o_addr_control = ~(~i_hit & i_dirty);
            end
            ALLOCATE: begin
                o_start_read          = 1'b1;
                o_data_block_write_en = i_r_last;
                o_valid_update        = i_r_last;
            end
            WRITE_BACK: begin
                o_start_write = 1'b1;
            end
            default: begin
                o_stall = 1'b1;
            end
        endcase
    end

endmodule

// ==== design/mem_burst_ctrl.sv ====
`timescale 1ns/1ps

module mem_burst_ctrl
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               arstn,
    input  logic               i_start_read,
    input  logic               i_start_write,
    input  logic               i_addr_control,
    input  t_cache_addr        i_addr,
    input  logic [TAG_W-1:0]   i_victim_tag,
    input  logic [BLOCK_W-1:0] i_victim_block,
    output logic               o_r_last,
    output logic               o_b_resp,
    output logic [BLOCK_W-1:0] o_fill_block,

    // Read address and data.
    output logic               o_mem_ar_valid,
    output t_cache_addr        o_mem_ar_addr,
    input  logic               i_mem_ar_ready,
    input  logic               i_mem_r_valid,
    input  logic [WORD_W-1:0]  i_mem_r_data,
    input  logic               i_mem_r_last,

    // Write address, data and response.
    output logic               o_mem_aw_valid,
    output t_cache_addr        o_mem_aw_addr,
    input  logic               i_mem_aw_ready,
    output logic               o_mem_w_valid,
    output logic [WORD_W-1:0]  o_mem_w_data,
    output logic               o_mem_w_last,
    input  logic               i_mem_w_ready,
    input  logic               i_mem_b_valid
);

    logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] line_buf;
    logic [WORDS_PER_BLOCK-1:0][WORD_W-1:0] wb_block;

    logic [WORD_SEL_W-1:0] rd_cnt;
    logic [WORD_SEL_W-1:0] wr_cnt;
    logic                  rd_issued;
    logic                  wr_issued;

    // --------------------------------------------------
    // Read engine.
    // --------------------------------------------------
    always_comb begin
        o_mem_ar_addr.flat = {i_addr.flat[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            o_mem_ar_valid <= 1'b0;
            o_r_last       <= 1'b0;
            rd_issued      <= 1'b0;
            rd_cnt         <= '0;
        end else begin
            o_r_last <= i_mem_r_valid && i_mem_r_last;
            // One burst per request, re-armed when the FSM leaves ALLOCATE.
            if (!i_start_read) begin
                rd_issued <= 1'b0;
                rd_cnt    <= '0;
            end else if (!rd_issued) begin
                rd_issued      <= 1'b1;
                o_mem_ar_valid <= 1'b1;
            end
            if (o_mem_ar_valid && i_mem_ar_ready) begin
                o_mem_ar_valid <= 1'b0;
            end
            if (i_mem_r_valid) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_mem_r_valid) begin
            line_buf[rd_cnt] <= i_mem_r_data;
        end
    end

    assign o_fill_block = line_buf;

    // --------------------------------------------------
    // Write engine.
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!i_addr_control) begin
            wb_block           <= i_victim_block;
            o_mem_aw_addr.flat <= {i_victim_tag, i_addr.fields.index, {OFFSET_W{1'b0}}};
        end
    end

    assign o_mem_w_data = wb_block[wr_cnt];
    assign o_mem_w_last = (wr_cnt == WORD_SEL_W'(WORDS_PER_BLOCK - 1));

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            o_mem_aw_valid <= 1'b0;
            o_mem_w_valid  <= 1'b0;
            o_b_resp       <= 1'b0;
            wr_issued      <= 1'b0;
            wr_cnt         <= '0;
        end else begin
            o_b_resp <= i_mem_b_valid;
            if (!i_start_write) begin
                wr_issued <= 1'b0;
            end else if (!wr_issued) begin
                wr_issued      <= 1'b1;
                o_mem_aw_valid <= 1'b1;
                o_mem_w_valid  <= 1'b1;
                wr_cnt         <= '0;
            end
            if (o_mem_aw_valid && i_mem_aw_ready) begin
                o_mem_aw_valid <= 1'b0;
            end
            // Data beats advance on their own handshake.
            if (o_mem_w_valid && i_mem_w_ready) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (o_mem_w_last) begin
                    o_mem_w_valid <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the data cache testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_data_cache -f sim.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_data_cache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== sim.f ====
design/cache_pkg.sv
design/data_cache_fsm.sv
design/cache_tag_array.sv
design/cache_data_array.sv
design/cache_lru.sv
design/mem_burst_ctrl.sv
design/data_cache.sv
verification/tb_data_cache.sv

// ==== verification/tb_data_cache.sv ====
`timescale 1ns/1ps

module tb_data_cache
    import cache_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int ROUNDS         = 300;

    logic              clk            = 1'b0;
    logic              arstn          = 1'b0;
    logic              i_req          = 1'b0;
    logic              i_we           = 1'b0;
    t_cache_addr       i_addr         = '0;
    logic [WORD_W-1:0] i_wdata        = '0;
    logic [WORD_W-1:0] o_rdata;
    logic              o_stall;
    logic              o_mem_ar_valid;
    t_cache_addr       o_mem_ar_addr;
    logic              i_mem_ar_ready = 1'b0;
    logic              i_mem_r_valid  = 1'b0;
    logic [WORD_W-1:0] i_mem_r_data   = '0;
    logic              i_mem_r_last   = 1'b0;
    logic              o_mem_aw_valid;
    t_cache_addr       o_mem_aw_addr;
    logic              i_mem_aw_ready = 1'b0;
    logic              o_mem_w_valid;
    logic [WORD_W-1:0] o_mem_w_data;
    logic              o_mem_w_last;
    logic              i_mem_w_ready  = 1'b0;
    logic              i_mem_b_valid  = 1'b0;

    integer seed       = 32'he435_4067;
    integer delay_seed = 32'he435_4067;
    int     errors     = 0;
    int     checks     = 0;
    int     wb_count   = 0;
    logic   timed_out  = 1'b0;

    // Backing memory and the reference copy, one entry per word.
    logic [WORD_W-1:0] mem   [4096];
    logic [WORD_W-1:0] model [4096];
    logic              held_dirty [1024];

    // Responder state.
    logic              rd_active;
    logic              aw_done;
    logic              w_done;
    logic [9:0]        rd_blk;
    logic [9:0]        wb_blk;
    logic [9:0]        last_wb_blk;
    logic [1:0]        rd_beat;
    logic [1:0]        w_beat;
    logic [1:0]        ar_wait;
    logic [1:0]        r_wait;
    logic [1:0]        aw_wait;
    logic [1:0]        w_wait;
    logic [1:0]        b_wait;
    logic [WORD_W-1:0] wbuf [4];

    data_cache dut0 (.*);

    always #10 clk = ~clk;

    function automatic logic [1:0] rand_delay();
        logic [31:0] r;
        r = $random(delay_seed);
        return r[1:0];
    endfunction

    function automatic t_cache_addr make_addr(input logic [2:0] tag, input logic [3:0] index,
                                              input logic [1:0] word);
        t_cache_addr a;
        a.flat         = '0;
        a.fields.tag   = {21'd0, tag};
        a.fields.index = index;
        a.fields.word  = word;
        return a;
    endfunction

    task automatic check_quiet_outputs();
        checks++;
        assert (o_stall && !o_mem_ar_valid && !o_mem_aw_valid && !o_mem_w_valid) else begin
            errors++;
            $display("ERROR at %0t: stall low or a memory valid high around reset", $time);
        end
    endtask

    // One processor request, held until the cache stops stalling.
    task automatic access(input logic we, input t_cache_addr addr,
                          input logic [WORD_W-1:0] wdata, output int cycles);
        logic              done;
        logic [WORD_W-1:0] rdata;
        done   = 1'b0;
        rdata  = '0;
        cycles = 0;
        if (!timed_out) begin
            @(posedge clk);
            i_req   <= 1'b1;
            i_we    <= we;
            i_addr  <= addr;
            i_wdata <= wdata;
            while (!done && cycles < TIMEOUT_CYCLES) begin
                @(negedge clk);
                cycles++;
                if (!o_stall) begin
                    done  = 1'b1;
                    rdata = o_rdata;
                end
            end
            if (!done) begin
                errors++;
                timed_out = 1'b1;
                $display("Timeout: the cache never finished the request to address %h",
                         addr.flat);
            end else begin
                @(posedge clk);
                i_req <= 1'b0;
                i_we  <= 1'b0;
                if (we) begin
                    model[addr.flat[13:2]]      = wdata;
                    held_dirty[addr.flat[13:4]] = 1'b1;
                end else begin
                    checks++;
                    assert (rdata == model[addr.flat[13:2]]) else begin
                        errors++;
                        $display("ERROR at %0t: read of %h returned %h, expected %h", $time,
                                 addr.flat, rdata, model[addr.flat[13:2]]);
                    end
                end
            end
        end
    endtask

    // --------------------------------------------------
    // Memory responder.
    // --------------------------------------------------
    always @(posedge clk) begin
        if (!arstn) begin
            i_mem_ar_ready <= 1'b0;
            i_mem_r_valid  <= 1'b0;
            i_mem_r_last   <= 1'b0;
            i_mem_aw_ready <= 1'b0;
            i_mem_w_ready  <= 1'b0;
            i_mem_b_valid  <= 1'b0;
            rd_active      <= 1'b0;
            aw_done        <= 1'b0;
            w_done         <= 1'b0;
            w_beat         <= 2'd0;
            ar_wait        <= rand_delay();
            r_wait         <= rand_delay();
            aw_wait        <= rand_delay();
            w_wait         <= rand_delay();
            b_wait         <= rand_delay();
        end else begin
            // Read address.
            if (o_mem_ar_valid && i_mem_ar_ready) begin
                i_mem_ar_ready <= 1'b0;
                rd_active      <= 1'b1;
                rd_blk         <= o_mem_ar_addr.flat[13:4];
                rd_beat        <= 2'd0;
                ar_wait        <= rand_delay();
                checks++;
                assert (o_mem_ar_addr.flat[3:0] == 4'h0 &&
                        !held_dirty[o_mem_ar_addr.flat[13:4]]) else begin
                    errors++;
                    $display("ERROR at %0t: read burst at %h is unaligned or dirty", $time,
                             o_mem_ar_addr.flat);
                end
            end else if (o_mem_ar_valid) begin
                if (ar_wait == 2'd0) begin
                    i_mem_ar_ready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end
            // Read beats, one cycle each.
            if (i_mem_r_valid) begin
                i_mem_r_valid <= 1'b0;
                i_mem_r_last  <= 1'b0;
                rd_beat       <= rd_beat + 2'd1;
                if (i_mem_r_last) begin
                    rd_active <= 1'b0;
                end
            end else if (rd_active) begin
                if (r_wait == 2'd0) begin
                    i_mem_r_valid <= 1'b1;
                    i_mem_r_data  <= mem[{rd_blk, rd_beat}];
                    i_mem_r_last  <= (rd_beat == 2'd3);
                    r_wait        <= rand_delay();
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
            // Write address.
            if (o_mem_aw_valid && i_mem_aw_ready) begin
                i_mem_aw_ready <= 1'b0;
                aw_done        <= 1'b1;
                wb_blk         <= o_mem_aw_addr.flat[13:4];
                aw_wait        <= rand_delay();
                checks++;
                assert (o_mem_aw_addr.flat[3:0] == 4'h0) else begin
                    errors++;
                    $display("ERROR at %0t: write burst at %h is unaligned", $time,
                             o_mem_aw_addr.flat);
                end
            end else if (o_mem_aw_valid) begin
                if (aw_wait == 2'd0) begin
                    i_mem_aw_ready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 2'd1;
                end
            end
            // Write beats.
            if (o_mem_w_valid && i_mem_w_ready) begin
                i_mem_w_ready  <= 1'b0;
                wbuf[w_beat]   <= o_mem_w_data;
                w_beat         <= w_beat + 2'd1;
                w_wait         <= rand_delay();
                if (w_beat == 2'd3) begin
                    w_done <= 1'b1;
                end
                checks++;
                assert (o_mem_w_last == (w_beat == 2'd3)) else begin
                    errors++;
                    $display("ERROR at %0t: w_last is %b on beat %0d", $time, o_mem_w_last,
                             w_beat);
                end
            end else if (o_mem_w_valid) begin
                if (w_wait == 2'd0) begin
                    i_mem_w_ready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 2'd1;
                end
            end
            // Response once address and all data are in; memory updated here.
            if (i_mem_b_valid) begin
                i_mem_b_valid <= 1'b0;
            end else if (aw_done && w_done) begin
                if (b_wait == 2'd0) begin
                    i_mem_b_valid <= 1'b1;
                    aw_done       <= 1'b0;
                    w_done        <= 1'b0;
                    b_wait        <= rand_delay();
                    for (int k = 0; k < 4; k++) begin
                        checks++;
                        assert (wbuf[k[1:0]] == model[{wb_blk, k[1:0]}]) else begin
                            errors++;
                            $display("ERROR at %0t: write-back block %h word %0d is %h, expected %h",
                                     $time, wb_blk, k, wbuf[k[1:0]], model[{wb_blk, k[1:0]}]);
                        end
                        mem[{wb_blk, k[1:0]}] = wbuf[k[1:0]];
                    end
                    held_dirty[wb_blk] = 1'b0;
                    last_wb_blk        = wb_blk;
                    wb_count++;
                end else begin
                    b_wait <= b_wait - 2'd1;
                end
            end
        end
    end

    // --------------------------------------------------
    // Stimulus.
    // --------------------------------------------------
    initial begin
        logic [31:0]       r;
        logic [WORD_W-1:0] wdata;
        t_cache_addr       addr;
        int                cycles;
        int                wb_before;
        for (int i = 0; i < 4096; i++) begin
            mem[i[11:0]]   = $random(seed);
            model[i[11:0]] = mem[i[11:0]];
        end
        for (int b = 0; b < 1024; b++) begin
            held_dirty[b[9:0]] = 1'b0;
        end

        repeat (16) begin
            @(negedge clk);
            check_quiet_outputs();
        end
        @(posedge clk);
        arstn <= 1'b1;
        @(negedge clk);
        check_quiet_outputs();

        // Set 5 gets tags 1 to 4 dirty, tag 1 is touched, so tag 5 evicts tag 2.
        for (int t = 1; t <= 4; t++) begin
            wdata = $random(seed);
            access(1'b1, make_addr(t[2:0], 4'd5, 2'd0), wdata, cycles);
        end
        access(1'b0, make_addr(3'd1, 4'd5, 2'd0), '0, cycles);
        wb_before = wb_count;
        wdata     = $random(seed);
        access(1'b1, make_addr(3'd5, 4'd5, 2'd1), wdata, cycles);
        addr = make_addr(3'd2, 4'd5, 2'd0);
        if (!timed_out) begin
            checks++;
            assert (wb_count == wb_before + 1 && last_wb_blk == addr.flat[13:4]) else begin
                errors++;
                $display("ERROR at %0t: LRU evicted block %h, expected %h", $time,
                         last_wb_blk, addr.flat[13:4]);
            end
        end

        // Random traffic; each access is followed by a hit in the same block.
        for (int n = 0; n < ROUNDS && !timed_out; n++) begin
            r     = $random(seed);
            wdata = $random(seed);
            addr  = make_addr(r[2:0], r[6:3], r[8:7]);
            access(r[9], addr, wdata, cycles);
            r                = $random(seed);
            wdata            = $random(seed);
            addr.fields.word = r[1:0];
            access(r[2], addr, wdata, cycles);
            if (!timed_out) begin
                checks++;
                assert (cycles == 2) else begin
                    errors++;
                    $display("ERROR at %0t: repeat access to %h took %0d cycles, expected 2",
                             $time, addr.flat, cycles);
                end
            end
        end

        // Read every word back.
        for (int w = 0; w < 512 && !timed_out; w++) begin
            access(1'b0, make_addr(w[8:6], w[5:2], w[1:0]), '0, cycles);
        end

        $display("Errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
